//--- vlog.f
+incdir+bench
logic/params_pkg.sv
logic/settings_pkg.sv
logic/cpu_bus_bridge.sv
logic/controller_regs.sv
logic/mod_memory.sv
logic/mod_sampler.sv
logic/mod_ctrl_top.sv
bench/tb_mod_ctrl_top.sv

//--- run_verilator.sh
#!/bin/sh
# Builds and runs the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_mod_ctrl_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

//--- bench/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Each task starts and ends 2 ns after a rising edge.
task automatic bus_write(input logic [SELECT_W-1:0] sel, input logic [ADDR_W-1:0] addr,
                         input logic [15:0] data);
  cpu_addr = {sel, addr};
  cpu_data_in = data;
  cpu_cs1_n = 1'b0;
  cpu_we0_n = 1'b0;
  repeat (2) @(posedge CPU_CKIO);
  #2;
  cpu_cs1_n = 1'b1;
  cpu_we0_n = 1'b1;
  @(posedge CPU_CKIO);  // One idle sample between accesses.
  #2;
endtask

// Data is valid 3 clocks after the first low sample of rd0_n.
task automatic bus_read(input logic [SELECT_W-1:0] sel, input logic [ADDR_W-1:0] addr,
                        output logic [15:0] data);
  cpu_addr = {sel, addr};
  cpu_cs1_n = 1'b0;
  cpu_rd0_n = 1'b0;
  repeat (2) @(posedge CPU_CKIO);
  #2;
  cpu_cs1_n = 1'b1;
  cpu_rd0_n = 1'b1;
  repeat (2) @(posedge CPU_CKIO);
  #2;
  data = cpu_data_out;
endtask

task automatic write_mod_settings(input mod_settings_t s);
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_0, 16'(s.cycle_0));
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_0, s.freq_div_0[15:0]);
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_1, s.freq_div_0[31:16]);
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_1, 16'(s.cycle_1));
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_1_0, s.freq_div_1[15:0]);
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_1_1, s.freq_div_1[31:16]);
  // Segment request last, so playback restarts on the new timing.
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_REQ_RD_SEGMENT, 16'(s.req_rd_segment));
endtask

task automatic write_mod(input logic seg);
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, {15'd0, seg});
  for (int w = 0; w < TB_MOD_WORDS; w++) begin
    bus_write(BRAM_SELECT_MOD, ADDR_W'(w), {mod_bytes[seg][2*w+1], mod_bytes[seg][2*w]});
  end
endtask

`endif

//--- bench/tb_mod_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mod_ctrl_top;
  import params_pkg::*;
  import settings_pkg::*;

  localparam int TB_MOD_WORDS = 16;
  localparam int TABLE_LEN = 24;
  localparam int BUS_CYCLES = 6;  // Upper bound per bus access.
  localparam int PLAY_STEPS = 24;
  localparam int ACCESSES = TABLE_LEN + 2 * (TB_MOD_WORDS + 1) + 8;
  localparam int CYCLE_LIMIT = 2 * (3 + ACCESSES * BUS_CYCLES + 4 * PLAY_STEPS);

  typedef struct packed {
    logic is_read;
    logic [SELECT_W-1:0] sel;
    logic [ADDR_W-1:0] addr;
    logic [15:0] data;
    logic [15:0] expected;
  } bus_step_t;

  logic CPU_CKIO;
  logic rst_n;
  logic [15:0] cpu_addr;
  logic [15:0] cpu_data_in;
  logic [15:0] cpu_data_out;
  logic cpu_cs1_n;
  logic cpu_we0_n;
  logic cpu_rd0_n;
  logic [7:0] mod_value;
  logic [CYCLE_W-1:0] mod_idx;
  logic mod_segment;

  bus_step_t steps[TABLE_LEN];
  logic [7:0] mod_bytes[2][2*TB_MOD_WORDS];  // Reference copy of both segments.
  int seed = 32'h9762a085;
  int cycles = 0;

  mod_ctrl_top #(
    .MOD_WORDS(TB_MOD_WORDS)
  ) u_dut (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .cpu_addr(cpu_addr),
    .cpu_data_in(cpu_data_in),
    .cpu_data_out(cpu_data_out),
    .cpu_cs1_n(cpu_cs1_n),
    .cpu_we0_n(cpu_we0_n),
    .cpu_rd0_n(cpu_rd0_n),
    .mod_value(mod_value),
    .mod_idx(mod_idx),
    .mod_segment(mod_segment)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #10 CPU_CKIO = ~CPU_CKIO;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                          input string what);
    if (got !== expected) begin
      fail_run($sformatf("MISMATCH at %0t ns: %s, got %0h, expected %0h",
                         $time, what, got, expected));
    end
  endtask

  always @(posedge CPU_CKIO) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) fail_run("Timeout: the run went past its cycle limit.");
  end

  `include "tb_bus_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Playback checker, sampled on the falling edge.
  //////////////////////////////////////////////////////////////////////

  task automatic observe_playback(input logic seg, input int last_idx, input int freq_div,
                                  input int n_steps);
    int div_eff;
    int wait_cnt;
    int held;
    int prev_idx;
    int changes;
    div_eff = (freq_div == 0) ? 1 : freq_div;
    wait_cnt = 0;
    while (mod_segment !== seg) begin
      @(negedge CPU_CKIO);
      wait_cnt++;
      if (wait_cnt > 20 * BUS_CYCLES) fail_run("Playback never moved to the requested segment.");
    end
    check_eq(32'(mod_idx), 0, "mod_idx after segment switch");
    held = 1;
    prev_idx = 0;
    changes = 0;
    while (changes < n_steps) begin
      check_eq(32'(mod_segment), 32'(seg), "mod_segment during playback");
      check_eq(32'(mod_value), 32'(mod_bytes[seg][int'(mod_idx)]), "mod_value at mod_idx");
      @(negedge CPU_CKIO);
      if (int'(mod_idx) == prev_idx) begin
        held++;
      end else begin
        check_eq(held, div_eff, "clocks per mod_idx step");
        check_eq(int'(mod_idx), (prev_idx == last_idx) ? 0 : prev_idx + 1, "mod_idx order");
        prev_idx = int'(mod_idx);
        held = 1;
        changes++;
      end
    end
  endtask

  initial begin
    logic [15:0] rd_data;
    bit cycle_zero;
    mod_settings_t s;
    // Reset defaults, then register readback.
    steps[0] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0000, 16'h0000};
    steps[1] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_REQ_RD_SEGMENT, 16'h0000, 16'h0000};
    steps[2] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_0, 16'h0000, 16'h0000};
    steps[3] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_0, 16'h0000, 16'h000a};
    steps[4] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_1, 16'h0000, 16'h0000};
    steps[5] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_1, 16'h0000, 16'h0000};
    steps[6] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_1_0, 16'h0000, 16'h000a};
    steps[7] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_1_1, 16'h0000, 16'h0000};
    steps[8] = '{1'b0, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_0, 16'h1234, 16'h0000};
    steps[9] = '{1'b0, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_1, 16'habcd, 16'h0000};
    steps[10] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_0, 16'h0000, 16'h1234};
    steps[11] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_0_1, 16'h0000, 16'habcd};
    steps[12] = '{1'b0, BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_0, 16'hffff, 16'h0000};
    steps[13] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_0, 16'h0000, 16'h7fff};  // 15 bits.
    steps[14] = '{1'b0, BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_1, 16'h0155, 16'h0000};
    steps[15] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE_1, 16'h0000, 16'h0155};
    steps[16] = '{1'b0, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_1_1, 16'h8001, 16'h0000};
    steps[17] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_FREQ_DIV_1_1, 16'h0000, 16'h8001};
    steps[18] = '{1'b0, BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0001, 16'h0000};
    steps[19] = '{1'b1, BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0000, 16'h0001};
    steps[20] = '{1'b0, BRAM_SELECT_CONTROLLER, 14'h0030, 16'hffff, 16'h0000};
    steps[21] = '{1'b1, BRAM_SELECT_CONTROLLER, 14'h0030, 16'h0000, 16'h0000};  // Unmapped.
    steps[22] = '{1'b1, 2'd2, ADDR_MOD_FREQ_DIV_0_0, 16'h0000, 16'h0000};
    steps[23] = '{1'b1, 2'd3, ADDR_MOD_CYCLE_1, 16'h0000, 16'h0000};
    rst_n = 1'b0;
    cpu_addr = '0;
    cpu_data_in = '0;
    cpu_cs1_n = 1'b1;
    cpu_we0_n = 1'b1;
    cpu_rd0_n = 1'b1;
    cycle_zero = 1'b1;
    repeat (3) @(posedge CPU_CKIO);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < TABLE_LEN; i++) begin
      if (cycle_zero) check_eq(32'(mod_idx), 0, "mod_idx while cycle_0 is 0");
      if (steps[i].is_read) begin
        bus_read(steps[i].sel, steps[i].addr, rd_data);
        check_eq(32'(rd_data), 32'(steps[i].expected), $sformatf("table entry %0d", i));
      end else begin
        bus_write(steps[i].sel, steps[i].addr, steps[i].data);
        if (steps[i].addr == ADDR_MOD_CYCLE_0) cycle_zero = 1'b0;
      end
    end
    // Random modulation data for both segments.
    for (int sg = 0; sg < 2; sg++) begin
      for (int b = 0; b < 2 * TB_MOD_WORDS; b++) mod_bytes[sg][b] = 8'($random(seed));
    end
    write_mod(1'b0);
    write_mod(1'b1);
    s = '{req_rd_segment: 1'b1, cycle_0: 15'd9, freq_div_0: 32'd3, cycle_1: 15'd5,
          freq_div_1: 32'd0};
    fork
      write_mod_settings(s);
      observe_playback(1'b1, 5, 0, PLAY_STEPS);
    join
    @(posedge CPU_CKIO);
    #2;
    fork
      bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_REQ_RD_SEGMENT, 16'h0000);
      observe_playback(1'b0, 9, 3, PLAY_STEPS);
    join
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/mod_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module mod_ctrl_top #(
  parameter int MOD_WORDS = 256
) (
  input wire logic CPU_CKIO,
  input wire logic rst_n,
  input wire logic [15:0] cpu_addr,
  input wire logic [15:0] cpu_data_in,
  output logic [15:0] cpu_data_out,
  input wire logic cpu_cs1_n,
  input wire logic cpu_we0_n,
  input wire logic cpu_rd0_n,
  output logic [7:0] mod_value,
  output logic [settings_pkg::CYCLE_W-1:0] mod_idx,
  output logic mod_segment
);
  import params_pkg::*;
  import settings_pkg::*;

  logic ctrl_wr, ctrl_rd, mod_wr;
  logic [ADDR_W-1:0] bus_addr;
  logic [15:0] bus_data;
  logic wr_segment, req_rd_segment;
  logic [CYCLE_W-1:0] cycle_0, cycle_1;
  logic [FREQ_DIV_W-1:0] freq_div_0, freq_div_1;
  logic rd_segment;
  logic [$clog2(MOD_WORDS)-1:0] rd_addr;
  logic [15:0] rd_data;

  cpu_bus_bridge u_bridge (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .cpu_addr(cpu_addr),
    .cpu_data_in(cpu_data_in),
    .cpu_cs1_n(cpu_cs1_n),
    .cpu_we0_n(cpu_we0_n),
    .cpu_rd0_n(cpu_rd0_n),
    .ctrl_wr(ctrl_wr),
    .ctrl_rd(ctrl_rd),
    .mod_wr(mod_wr),
    .bus_addr(bus_addr),
    .bus_data(bus_data)
  );

  controller_regs u_regs (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .ctrl_wr(ctrl_wr),
    .ctrl_rd(ctrl_rd),
    .bus_addr(bus_addr),
    .bus_data(bus_data),
    .cpu_data_out(cpu_data_out),
    .wr_segment(wr_segment),
    .req_rd_segment(req_rd_segment),
    .cycle_0(cycle_0),
    .freq_div_0(freq_div_0),
    .cycle_1(cycle_1),
    .freq_div_1(freq_div_1)
  );

  mod_memory #(
    .MOD_WORDS(MOD_WORDS)
  ) u_mem (
    .CPU_CKIO(CPU_CKIO),
    .wr_en(mod_wr),
    .wr_segment(wr_segment),
    .wr_addr(bus_addr),
    .wr_data(bus_data),
    .rd_segment(rd_segment),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  mod_sampler #(
    .MOD_WORDS(MOD_WORDS)
  ) u_sampler (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .req_rd_segment(req_rd_segment),
    .cycle_0(cycle_0),
    .freq_div_0(freq_div_0),
    .cycle_1(cycle_1),
    .freq_div_1(freq_div_1),
    .rd_segment(rd_segment),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .mod_value(mod_value),
    .mod_idx(mod_idx),
    .mod_segment(mod_segment)
  );

endmodule

`default_nettype wire

//--- logic/mod_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module mod_sampler #(
  parameter int MOD_WORDS = 256
) (
  input wire logic CPU_CKIO,
  input wire logic rst_n,
  input wire logic req_rd_segment,
  input wire logic [settings_pkg::CYCLE_W-1:0] cycle_0,
  input wire logic [settings_pkg::FREQ_DIV_W-1:0] freq_div_0,
  input wire logic [settings_pkg::CYCLE_W-1:0] cycle_1,
  input wire logic [settings_pkg::FREQ_DIV_W-1:0] freq_div_1,
  output logic rd_segment,
  output logic [$clog2(MOD_WORDS)-1:0] rd_addr,
  input wire logic [15:0] rd_data,
  output logic [7:0] mod_value,
  output logic [settings_pkg::CYCLE_W-1:0] mod_idx,
  output logic mod_segment
);
  import settings_pkg::*;

  localparam int IDX_W = $clog2(2 * MOD_WORDS);

  logic seg;
  logic [IDX_W-1:0] idx;
  logic [FREQ_DIV_W-1:0] div_cnt;
  logic [FREQ_DIV_W-1:0] freq_div_cur;
  logic [FREQ_DIV_W-1:0] div_max;
  logic [IDX_W-1:0] idx_last;
  logic step;
  logic [IDX_W-1:0] idx_d;
  logic seg_d;

  assign freq_div_cur = seg ? freq_div_1 : freq_div_0;
  assign idx_last = seg ? cycle_1[IDX_W-1:0] : cycle_0[IDX_W-1:0];  // Truncated to range.
  assign div_max = (freq_div_cur == '0) ? '0 : freq_div_cur - 1'b1;
  assign step = (div_cnt >= div_max);

  //////////////////////////////////////////////////////////////////////
  // Divider and byte index.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      seg <= 1'b0;
      idx <= '0;
      div_cnt <= '0;
    end else if (req_rd_segment != seg) begin
      // Segment switch restarts playback.
      seg <= req_rd_segment;
      idx <= '0;
      div_cnt <= '0;
    end else if (step) begin
      div_cnt <= '0;
      idx <= (idx >= idx_last) ? '0 : idx + 1'b1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign rd_segment = seg;
  assign rd_addr = idx[IDX_W-1:1];

  //////////////////////////////////////////////////////////////////////
  // Output pipe, aligned with the memory read.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      idx_d <= '0;
      seg_d <= 1'b0;
      mod_value <= 8'h00;
      mod_idx <= '0;
      mod_segment <= 1'b0;
    end else begin
      idx_d <= idx;
      seg_d <= seg;
      mod_value <= idx_d[0] ? rd_data[15:8] : rd_data[7:0];  // Odd index takes high byte.
      mod_idx <= CYCLE_W'(idx_d);
      mod_segment <= seg_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/mod_memory.sv
`timescale 1ns/1ns
`default_nettype none

module mod_memory #(
  parameter int MOD_WORDS = 256
) (
  input wire logic CPU_CKIO,
  input wire logic wr_en,
  input wire logic wr_segment,
  input wire logic [params_pkg::ADDR_W-1:0] wr_addr,
  input wire logic [15:0] wr_data,
  input wire logic rd_segment,
  input wire logic [$clog2(MOD_WORDS)-1:0] rd_addr,
  output logic [15:0] rd_data
);
  localparam int WORD_AW = $clog2(MOD_WORDS);

  logic [15:0] mem[2][MOD_WORDS];

  // CPU side. Out of range words are dropped.
  always_ff @(posedge CPU_CKIO) begin
    if (wr_en && (int'(wr_addr) < MOD_WORDS)) begin
      mem[wr_segment][wr_addr[WORD_AW-1:0]] <= wr_data;
    end
  end

  // Sampler side.
  always_ff @(posedge CPU_CKIO) begin
    rd_data <= mem[rd_segment][rd_addr];
  end

endmodule

`default_nettype wire

//--- logic/controller_regs.sv
`timescale 1ns/1ns
`default_nettype none

module controller_regs (
  input wire logic CPU_CKIO,
  input wire logic rst_n,
  input wire logic ctrl_wr,
  input wire logic ctrl_rd,
  input wire logic [params_pkg::ADDR_W-1:0] bus_addr,
  input wire logic [15:0] bus_data,
  output logic [15:0] cpu_data_out,
  output logic wr_segment,
  output logic req_rd_segment,
  output logic [settings_pkg::CYCLE_W-1:0] cycle_0,
  output logic [settings_pkg::FREQ_DIV_W-1:0] freq_div_0,
  output logic [settings_pkg::CYCLE_W-1:0] cycle_1,
  output logic [settings_pkg::FREQ_DIV_W-1:0] freq_div_1
);
  import params_pkg::*;
  import settings_pkg::*;

  mod_settings_t bank;
  logic [15:0] rd_mux;
  logic [15:0] rd_word;
  logic rd_pend;

  //////////////////////////////////////////////////////////////////////
  // Register writes.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      wr_segment <= 1'b0;
      bank <= '{req_rd_segment: 1'b0, cycle_0: DEFAULT_CYCLE, freq_div_0: DEFAULT_FREQ_DIV,
                 cycle_1: DEFAULT_CYCLE, freq_div_1: DEFAULT_FREQ_DIV};
    end else if (ctrl_wr) begin
      case (bus_addr)
        ADDR_MOD_MEM_WR_SEGMENT: wr_segment <= bus_data[0];
        ADDR_MOD_REQ_RD_SEGMENT: bank.req_rd_segment <= bus_data[0];
        ADDR_MOD_CYCLE_0: bank.cycle_0 <= bus_data[CYCLE_W-1:0];
        ADDR_MOD_FREQ_DIV_0_0: bank.freq_div_0[15:0] <= bus_data;
        ADDR_MOD_FREQ_DIV_0_1: bank.freq_div_0[FREQ_DIV_W-1:16] <= bus_data;
        ADDR_MOD_CYCLE_1: bank.cycle_1 <= bus_data[CYCLE_W-1:0];
        ADDR_MOD_FREQ_DIV_1_0: bank.freq_div_1[15:0] <= bus_data;
        ADDR_MOD_FREQ_DIV_1_1: bank.freq_div_1[FREQ_DIV_W-1:16] <= bus_data;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Readback.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (bus_addr)
      ADDR_MOD_MEM_WR_SEGMENT: rd_mux = {15'd0, wr_segment};
      ADDR_MOD_REQ_RD_SEGMENT: rd_mux = {15'd0, bank.req_rd_segment};
      ADDR_MOD_CYCLE_0: rd_mux = {{(16 - CYCLE_W) {1'b0}}, bank.cycle_0};
      ADDR_MOD_FREQ_DIV_0_0: rd_mux = bank.freq_div_0[15:0];
      ADDR_MOD_FREQ_DIV_0_1: rd_mux = bank.freq_div_0[FREQ_DIV_W-1:16];
      ADDR_MOD_CYCLE_1: rd_mux = {{(16 - CYCLE_W) {1'b0}}, bank.cycle_1};
      ADDR_MOD_FREQ_DIV_1_0: rd_mux = bank.freq_div_1[15:0];
      ADDR_MOD_FREQ_DIV_1_1: rd_mux = bank.freq_div_1[FREQ_DIV_W-1:16];
      default: rd_mux = 16'h0000;  // Unmapped.
    endcase
  end

  always_ff @(posedge CPU_CKIO) begin
    if (ctrl_rd) rd_word <= rd_mux;
  end

  // Output stage of the read pipe. Holds until the next read.
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      cpu_data_out <= 16'h0000;
    end else begin
      rd_pend <= ctrl_rd;
      if (rd_pend) cpu_data_out <= rd_word;
    end
  end

  assign req_rd_segment = bank.req_rd_segment;
  assign cycle_0 = bank.cycle_0;
  assign freq_div_0 = bank.freq_div_0;
  assign cycle_1 = bank.cycle_1;
  assign freq_div_1 = bank.freq_div_1;

endmodule

`default_nettype wire

//--- logic/cpu_bus_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_bridge (
  input wire logic CPU_CKIO,
  input wire logic rst_n,
  input wire logic [params_pkg::SELECT_W+params_pkg::ADDR_W-1:0] cpu_addr,
  input wire logic [15:0] cpu_data_in,
  input wire logic cpu_cs1_n,
  input wire logic cpu_we0_n,
  input wire logic cpu_rd0_n,
  output logic ctrl_wr,
  output logic ctrl_rd,
  output logic mod_wr,
  output logic [params_pkg::ADDR_W-1:0] bus_addr,
  output logic [15:0] bus_data
);
  import params_pkg::*;

  logic [SELECT_W+ADDR_W-1:0] addr_q;
  logic [15:0] data_q;
  logic wr_q, wr_d;
  logic rd_q, rd_d;
  logic wr_pulse, rd_pulse;
  logic [SELECT_W-1:0] sel;

  // Input sampling.
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      wr_q <= 1'b0;
      wr_d <= 1'b0;
      rd_q <= 1'b0;
      rd_d <= 1'b0;
    end else begin
      wr_q <= ~cpu_cs1_n & ~cpu_we0_n;
      rd_q <= ~cpu_cs1_n & ~cpu_rd0_n;
      wr_d <= wr_q;
      rd_d <= rd_q;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data_in;
  end

  // One pulse per access, on the first active sample.
  assign wr_pulse = wr_q & ~wr_d;
  assign rd_pulse = rd_q & ~rd_d;
  assign sel = addr_q[ADDR_W+:SELECT_W];

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_wr <= 1'b0;
      ctrl_rd <= 1'b0;
      mod_wr <= 1'b0;
    end else begin
      ctrl_wr <= wr_pulse & (sel == BRAM_SELECT_CONTROLLER);
      mod_wr <= wr_pulse & (sel == BRAM_SELECT_MOD);
      ctrl_rd <= rd_pulse & (sel == BRAM_SELECT_CONTROLLER);  // Only registers read back.
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    bus_addr <= addr_q[ADDR_W-1:0];
    bus_data <= data_q;
  end

endmodule

`default_nettype wire

//--- logic/settings_pkg.sv
`default_nettype none

package settings_pkg;

  localparam int FREQ_DIV_W = 32;
  localparam int CYCLE_W = 15;  // Holds the last byte index.

  localparam logic [FREQ_DIV_W-1:0] DEFAULT_FREQ_DIV = 32'd10;
  localparam logic [CYCLE_W-1:0] DEFAULT_CYCLE = 15'd0;

  //////////////////////////////////////////////////////////////////////
  // Modulation playback settings, one set per segment.
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic req_rd_segment;
    logic [CYCLE_W-1:0] cycle_0;
    logic [FREQ_DIV_W-1:0] freq_div_0;
    logic [CYCLE_W-1:0] cycle_1;
    logic [FREQ_DIV_W-1:0] freq_div_1;
  } mod_settings_t;

endpackage

`default_nettype wire

//--- logic/params_pkg.sv
`default_nettype none

package params_pkg;

  //////////////////////////////////////////////////////////////////////
  // CPU bus field widths.
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 14;
  localparam int SELECT_W = 2;

  // Select codes in the top address bits.
  localparam logic [SELECT_W-1:0] BRAM_SELECT_CONTROLLER = 2'd0;
  localparam logic [SELECT_W-1:0] BRAM_SELECT_MOD = 2'd1;

  //////////////////////////////////////////////////////////////////////
  // Controller register word addresses.
  //////////////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] ADDR_MOD_MEM_WR_SEGMENT = 14'h0020;
  localparam logic [ADDR_W-1:0] ADDR_MOD_REQ_RD_SEGMENT = 14'h0021;

  // Segment 0 timing.
  localparam logic [ADDR_W-1:0] ADDR_MOD_CYCLE_0 = 14'h0022;
  localparam logic [ADDR_W-1:0] ADDR_MOD_FREQ_DIV_0_0 = 14'h0023;  // Low half.
  localparam logic [ADDR_W-1:0] ADDR_MOD_FREQ_DIV_0_1 = 14'h0024;  // High half.

  // Segment 1 timing.
  localparam logic [ADDR_W-1:0] ADDR_MOD_CYCLE_1 = 14'h0025;
  localparam logic [ADDR_W-1:0] ADDR_MOD_FREQ_DIV_1_0 = 14'h0026;
  localparam logic [ADDR_W-1:0] ADDR_MOD_FREQ_DIV_1_1 = 14'h0027;

endpackage

`default_nettype wire
